/* byte_fifo.sv */
`default_nettype none

module byte_fifo #(
    parameter int DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wr_valid,
    output logic                       wr_ready,
    input  logic [7:0]                 wr_data,
    output logic                       rd_valid,
    input  logic                       rd_ready,
    output logic [7:0]                 rd_data,
    output logic [$clog2(DEPTH+1)-1:0] level
);

    localparam int PW = $clog2(DEPTH);
    localparam int LW = $clog2(DEPTH + 1);

    logic [7:0]    mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic          do_wr;
    logic          do_rd;

    assign wr_ready = (level != LW'(DEPTH));
    assign rd_valid = (level != '0);
    assign do_wr    = wr_valid && wr_ready;
    assign do_rd    = rd_valid && rd_ready;
    assign rd_data  = mem[rd_ptr];   // Head of queue

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;    // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* frame_engine.sv */
`default_nettype none

module frame_engine import uart_bridge_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic [7:0]  in_data,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [7:0]  out_data,
    output logic        bus_valid,
    output logic        bus_write,
    output logic [7:0]  bus_addr,
    output logic [31:0] bus_wdata,
    input  logic        bus_ready,
    input  logic [31:0] bus_rdata,
    input  logic [7:0]  bus_status,
    input  logic        clear_stats,
    output logic [15:0] frame_count,
    output logic [15:0] error_count
);

    localparam int TW = $clog2(FRAME_TIMEOUT);

    localparam logic [2:0] S_CMD    = 3'd0;
    localparam logic [2:0] S_ADDR   = 3'd1;
    localparam logic [2:0] S_DATA   = 3'd2;   // Write payload bytes
    localparam logic [2:0] S_BUS    = 3'd3;   // Register access pending
    localparam logic [2:0] S_STATUS = 3'd4;
    localparam logic [2:0] S_RDATA  = 3'd5;   // Read payload bytes

    logic [2:0]    state;
    logic [1:0]    byte_cnt;
    logic [TW-1:0] idle_cnt;    // Silent cycles in a partial frame
    logic [7:0]    status;
    logic [31:0]   rdata;
    logic          accept;
    logic          partial;
    logic          timeout;
    logic          status_sent;

    assign in_ready    = (state == S_CMD) || partial;
    assign accept      = in_valid && in_ready;
    assign partial     = (state == S_ADDR) || (state == S_DATA);
    assign timeout     = partial && !in_valid && (idle_cnt == TW'(FRAME_TIMEOUT - 1));
    assign bus_valid   = (state == S_BUS);
    assign out_valid   = (state == S_STATUS) || (state == S_RDATA);
    assign out_data    = (state == S_STATUS) ? status : rdata[7:0];
    assign status_sent = (state == S_STATUS) && out_ready;

    // Frame payload and response data
    always_ff @(posedge clk) begin
        if (accept) begin
            case (state)
                S_CMD: begin
                    bus_write <= (in_data == CMD_WRITE);
                    status    <= ST_BAD_CMD;    // Replaced by bus status for good commands
                end
                S_ADDR:  bus_addr <= in_data;
                default: bus_wdata <= {in_data, bus_wdata[31:8]};   // LSB first
            endcase
        end
        if (bus_valid && bus_ready) begin
            status <= bus_status;
            rdata  <= bus_rdata;
        end else if ((state == S_RDATA) && out_ready) begin
            rdata <= rdata >> 8;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= S_CMD;
            byte_cnt    <= '0;
            idle_cnt    <= '0;
            frame_count <= '0;
            error_count <= '0;
        end else begin
            if (accept || !partial)
                idle_cnt <= '0;
            else
                idle_cnt <= idle_cnt + 1'b1;

            case (state)
                S_CMD: begin
                    if (in_valid) begin
                        if ((in_data == CMD_WRITE) || (in_data == CMD_READ))
                            state <= S_ADDR;
                        else
                            state <= S_STATUS;  // Unknown command answered at once
                    end
                end
                S_ADDR: begin
                    if (in_valid) begin
                        byte_cnt <= '0;
                        state    <= bus_write ? S_DATA : S_BUS;
                    end
                end
                S_DATA: begin
                    if (in_valid) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3)
                            state <= S_BUS;
                    end
                end
                S_BUS: begin
                    if (bus_ready)
                        state <= S_STATUS;
                end
                S_STATUS: begin
                    if (out_ready) begin
                        byte_cnt <= '0;
                        state    <= (!bus_write && status == ST_OK) ? S_RDATA : S_CMD;
                    end
                end
                default: begin
                    if (out_ready) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3)
                            state <= S_CMD;
                    end
                end
            endcase

            if (timeout)
                state <= S_CMD;     // Drop stalled frame silently

            // Statistics
            if (clear_stats) begin
                frame_count <= '0;
                error_count <= '0;
            end else if (status_sent && status == ST_OK) begin
                frame_count <= frame_count + 1'b1;
            end else if (status_sent || timeout) begin
                error_count <= error_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* project.f */
uart_bridge_pkg.sv
uart_rx.sv
uart_tx.sv
byte_fifo.sv
frame_engine.sv
reg_block.sv
uart_bridge_top.sv
tb_uart_bridge.sv

/* reg_block.sv */
`default_nettype none

module reg_block import uart_bridge_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        bus_valid,
    input  logic        bus_write,
    input  logic [7:0]  bus_addr,
    input  logic [31:0] bus_wdata,
    output logic        bus_ready,
    output logic [31:0] bus_rdata,
    output logic [7:0]  bus_status,
    output logic        clear_stats,
    input  logic [15:0] frame_count,
    input  logic [15:0] error_count
);

    logic [31:0] scratch;
    logic        req;       // New request this cycle

    // Master drops valid the cycle after ready
    assign req = bus_valid && !bus_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus_ready   <= 1'b0;
            bus_rdata   <= '0;
            bus_status  <= ST_OK;
            clear_stats <= 1'b0;
            scratch     <= '0;
        end else begin
            bus_ready   <= req;     // One cycle response
            clear_stats <= 1'b0;
            if (req) begin
                bus_rdata  <= '0;
                bus_status <= ST_OK;
                case (bus_addr)
                    ADDR_CTRL: begin
                        clear_stats <= bus_write && bus_wdata[0];   // Self clearing
                    end
                    ADDR_SCRATCH: begin
                        bus_rdata <= scratch;
                        if (bus_write)
                            scratch <= bus_wdata;
                    end
                    ADDR_STATUS: begin
                        bus_rdata <= {error_count, frame_count};
                        if (bus_write)
                            bus_status <= ST_READ_ONLY;
                    end
                    ADDR_ID: begin
                        bus_rdata <= ID_VALUE;
                        if (bus_write)
                            bus_status <= ST_READ_ONLY;
                    end
                    default: begin
                        bus_status <= ST_BAD_ADDR;  // Unmapped
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run, result taken from the simulation output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_uart_bridge -f project.f -o tb_uart_bridge &&
./obj_dir/tb_uart_bridge | tee /dev/stderr | grep -x "sim passed" > /dev/null &&
echo "Simulation result: PASS" ||
{ echo "Simulation result: FAIL"; exit 1; }

/* tb_uart_bridge.sv */
`default_nettype none

module tb_uart_bridge import uart_bridge_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BYTE_CYCLES    = 10 * CLKS_PER_BIT;    // One serial character
    localparam int RESP_LIMIT     = 8 * BYTE_CYCLES;      // Request plus turnaround
    localparam int GAP_LIMIT      = 2 * BYTE_CYCLES;      // Between response bytes
    localparam int WR_FRAME_BYTES = 6;                    // Command, address, four data bytes

    logic clk;
    logic rst;
    logic uart_rx;
    logic uart_tx;
    logic uart_rts_n;
    logic uart_cts_n;
    logic led;

    integer      seed;
    int          check_count;
    int          error_count;
    int          timeout_count;
    int          ok_tally;        // Frames answered ST_OK since last clear
    int          err_tally;       // Everything else including dropped frames
    int          frames_sent;
    int          queued;          // Burst bytes waiting in the rx FIFO
    int          n;
    logic [31:0] scratch_model;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [7:0]  status;
    logic [7:0]  rx_byte;
    logic        got;
    logic        rts_seen;

    uart_bridge_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .uart_rx    (uart_rx),
        .uart_tx    (uart_tx),
        .uart_rts_n (uart_rts_n),
        .uart_cts_n (uart_cts_n),
        .led        (led)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    task automatic expect_val(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        check_count++;
        assert (actual === expected)
        else begin
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            error_count++;
        end
    endtask

    // Host side serial driver
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};    // Stop, data, start
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            uart_rx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic send_frame(input logic [7:0] cmd, input logic [7:0] addr,
                              input logic [31:0] data);
        send_byte(cmd);
        if (cmd == CMD_WRITE || cmd == CMD_READ)
            send_byte(addr);
        if (cmd == CMD_WRITE) begin
            for (int i = 0; i < 4; i++)
                send_byte(data[8*i +: 8]);  // LSB first
        end
    endtask

    // Host side serial receiver sampling mid-bit on the falling clock
    task automatic recv_byte(output logic [7:0] b, output logic ok, input int limit);
        int wait_cnt;
        b        = 'x;
        ok       = 1'b0;
        wait_cnt = 0;
        @(negedge clk);
        while (uart_tx !== 1'b0 && wait_cnt < limit) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (uart_tx !== 1'b0) begin
            $display("Timeout at %0t ns: no start bit on uart_tx within %0d cycles",
                     $time, limit);
            timeout_count++;
        end else begin
            repeat (CLKS_PER_BIT / 2) @(negedge clk);   // Centre of start bit
            expect_val(32'(uart_tx), 32'd0, "start bit on uart_tx");
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                b[i] = uart_tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            expect_val(32'(uart_tx), 32'd1, "stop bit on uart_tx");
            ok = 1'b1;
        end
    endtask

    // Status byte followed by four data bytes for a good read only
    task automatic collect_response(input logic [7:0] cmd, output logic [7:0] st,
                                    output logic [31:0] data);
        logic [7:0] b;
        logic       ok;
        data = '0;
        recv_byte(st, ok, RESP_LIMIT);
        if (ok && cmd == CMD_READ && st == ST_OK) begin
            for (int i = 0; i < 4; i++) begin
                recv_byte(b, ok, GAP_LIMIT);
                data[8*i +: 8] = b;
            end
        end
    endtask

    task automatic run_frame(input logic [7:0] cmd, input logic [7:0] addr,
                             input logic [31:0] data, output logic [7:0] st,
                             output logic [31:0] rd);
        fork
            send_frame(cmd, addr, data);
            collect_response(cmd, st, rd);  // Reply can start inside the last stop bit
        join
    endtask

    task automatic tally_status(input logic [7:0] st);
        if (st === ST_OK)
            ok_tally++;
        else
            err_tally++;
    endtask

    task automatic check_line_idle(input int cycles, input string what);
        int lows;
        lows = 0;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (uart_tx !== 1'b1)
                lows++;
        end
        expect_val(lows, 32'd0, what);
    endtask

    initial begin
        seed          = 32'ha35c8304;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        ok_tally      = 0;
        err_tally     = 0;
        queued        = 0;
        scratch_model = '0;
        rst           = 1'b1;
        uart_rx       = 1'b1;       // Line idle
        uart_cts_n    = 1'b0;       // Host ready to take bytes

        // Reset values
        repeat (2) begin
            @(negedge clk);
            expect_val(32'(uart_tx), 32'd1, "uart_tx during reset");
            expect_val(32'(led), 32'd0, "led during reset");
            expect_val(32'(uart_rts_n), 32'd1, "uart_rts_n during reset");
        end
        @(posedge clk);
        rst <= 1'b0;
        n = 0;
        @(negedge clk);
        while (uart_rts_n !== 1'b0 && n < 2) begin
            @(negedge clk);
            n++;
        end
        expect_val(32'(uart_rts_n), 32'd0, "uart_rts_n after reset release");
        expect_val(32'(uart_tx), 32'd1, "uart_tx after reset");
        expect_val(32'(led), 32'd0, "led after reset");

        // Plain register traffic
        wdata = $random(seed);
        run_frame(CMD_WRITE, ADDR_SCRATCH, wdata, status, rdata);
        expect_val(status, ST_OK, "SCRATCH write status");
        tally_status(status);
        scratch_model = wdata;
        run_frame(CMD_READ, ADDR_SCRATCH, 32'h0, status, rdata);
        expect_val(status, ST_OK, "SCRATCH read status");
        expect_val(rdata, scratch_model, "SCRATCH read data");
        tally_status(status);
        run_frame(CMD_READ, ADDR_ID, 32'h0, status, rdata);
        expect_val(status, ST_OK, "ID read status");
        expect_val(rdata, ID_VALUE, "ID read data");
        tally_status(status);

        // Error answers
        run_frame(CMD_READ, 8'h10, 32'h0, status, rdata);
        expect_val(status, ST_BAD_ADDR, "unmapped read status");
        tally_status(status);
        check_line_idle(2 * BYTE_CYCLES, "no data bytes after ST_BAD_ADDR");
        run_frame(CMD_WRITE, ADDR_ID, $random(seed), status, rdata);
        expect_val(status, ST_READ_ONLY, "ID write status");
        tally_status(status);
        run_frame(8'hFF, 8'h00, 32'h0, status, rdata);
        expect_val(status, ST_BAD_CMD, "unknown command status");
        tally_status(status);

        // STATUS read is counted only after its own reply
        run_frame(CMD_READ, ADDR_STATUS, 32'h0, status, rdata);
        expect_val(rdata, {err_tally[15:0], ok_tally[15:0]}, "STATUS counters");
        tally_status(status);
        run_frame(CMD_WRITE, ADDR_CTRL, 32'h1, status, rdata);
        expect_val(status, ST_OK, "CTRL clear status");
        ok_tally  = 0;              // Clear lands before this reply is counted
        err_tally = 0;
        tally_status(status);
        run_frame(CMD_READ, ADDR_STATUS, 32'h0, status, rdata);
        expect_val(rdata, 32'h0000_0001, "STATUS after clear");
        tally_status(status);

        // Stalled partial write gets dropped silently
        send_byte(CMD_WRITE);
        send_byte(ADDR_SCRATCH);
        check_line_idle(FRAME_TIMEOUT + BYTE_CYCLES, "no reply to dropped frame");
        err_tally++;
        run_frame(CMD_READ, ADDR_STATUS, 32'h0, status, rdata);
        expect_val(status, ST_OK, "STATUS read after drop");
        expect_val(rdata, {err_tally[15:0], ok_tally[15:0]}, "STATUS after drop");
        tally_status(status);

        // CTS holds the reply back
        @(posedge clk);
        uart_cts_n <= 1'b1;
        send_frame(CMD_READ, ADDR_ID, 32'h0);
        check_line_idle(3 * BYTE_CYCLES, "uart_tx idle while CTS blocked");
        @(posedge clk);
        uart_cts_n <= 1'b0;
        collect_response(CMD_READ, status, rdata);
        expect_val(status, ST_OK, "ID read status after CTS release");
        expect_val(rdata, ID_VALUE, "ID read data after CTS release");
        tally_status(status);

        // Write burst until RTS goes up with the host stopping at a frame boundary
        @(posedge clk);
        uart_cts_n <= 1'b1;
        rts_seen    = 1'b0;
        frames_sent = 0;
        while (!rts_seen && frames_sent < TX_FIFO_DEPTH + 4) begin
            wdata = $random(seed);
            send_frame(CMD_WRITE, ADDR_SCRATCH, wdata);
            repeat (4) @(negedge clk);
            // Tx FIFO takes TX_FIFO_DEPTH statuses, the engine then holds one frame
            if (frames_sent > TX_FIFO_DEPTH)
                queued = WR_FRAME_BYTES * (frames_sent - TX_FIFO_DEPTH);
            else
                queued = 0;
            expect_val(32'(uart_rts_n), 32'(queued >= RX_HIGH_MARK),
                       "uart_rts_n against bytes waiting");
            rts_seen      = uart_rts_n;
            scratch_model = wdata;
            frames_sent++;
        end
        expect_val(32'(rts_seen), 32'd1, "uart_rts_n raised during burst");
        @(posedge clk);
        uart_cts_n <= 1'b0;
        for (int i = 0; i < frames_sent; i++) begin
            recv_byte(rx_byte, got, (i == 0) ? RESP_LIMIT : GAP_LIMIT);
            expect_val(rx_byte, ST_OK, "queued write status");
            if (got)
                tally_status(rx_byte);
        end
        run_frame(CMD_READ, ADDR_SCRATCH, 32'h0, status, rdata);
        expect_val(rdata, scratch_model, "SCRATCH after burst");
        tally_status(status);
        run_frame(CMD_READ, ADDR_STATUS, 32'h0, status, rdata);
        expect_val(rdata, {err_tally[15:0], ok_tally[15:0]}, "final STATUS counters");

        $display("Checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* uart_bridge_pkg.sv */
`default_nettype none

package uart_bridge_pkg;

    // Serial bit timing, kept short for fast simulation
    localparam int CLKS_PER_BIT = 16;

    // Byte FIFO sizing
    localparam int RX_FIFO_DEPTH = 8;
    localparam int TX_FIFO_DEPTH = 8;
    localparam int RX_HIGH_MARK  = 6;   // RTS released at this fill level

    // Silence inside a partial frame before it is dropped
    localparam int FRAME_TIMEOUT = 2000;

    // Command bytes
    localparam logic [7:0] CMD_WRITE = 8'h57;   // 'W'
    localparam logic [7:0] CMD_READ  = 8'h52;   // 'R'

    // Register map, byte addresses
    localparam logic [7:0] ADDR_CTRL    = 8'h00;
    localparam logic [7:0] ADDR_SCRATCH = 8'h04;
    localparam logic [7:0] ADDR_STATUS  = 8'h08;
    localparam logic [7:0] ADDR_ID      = 8'h0C;

    localparam logic [31:0] ID_VALUE = 32'h5541_5254;   // "UART"

    // Response status codes
    localparam logic [7:0] ST_OK        = 8'h00;
    localparam logic [7:0] ST_BAD_ADDR  = 8'h01;
    localparam logic [7:0] ST_READ_ONLY = 8'h02;
    localparam logic [7:0] ST_BAD_CMD   = 8'h03;

    // Heartbeat LED tap
    localparam int HEARTBEAT_BIT = 10;

endpackage

`default_nettype wire

/* uart_bridge_top.sv */
`default_nettype none

module uart_bridge_top import uart_bridge_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic uart_rx,
    output logic uart_tx,
    output logic uart_rts_n,
    input  logic uart_cts_n,
    output logic led
);

    // Receive path
    logic       rx_valid;
    logic [7:0] rx_data;
    logic       in_valid;
    logic       in_ready;
    logic [7:0] in_data;
    logic [$clog2(RX_FIFO_DEPTH+1)-1:0] rx_level;

    // Transmit path
    logic       out_valid;
    logic       out_ready;
    logic [7:0] out_data;
    logic       tx_valid;
    logic       tx_ready;
    logic [7:0] tx_data;

    // Register bus
    logic        bus_valid;
    logic        bus_write;
    logic [7:0]  bus_addr;
    logic [31:0] bus_wdata;
    logic        bus_ready;
    logic [31:0] bus_rdata;
    logic [7:0]  bus_status;

    logic        clear_stats;
    logic [15:0] frame_count;
    logic [15:0] error_count;
    logic [HEARTBEAT_BIT:0] hb_cnt;

    uart_rx u_rx (
        .clk      (clk),
        .rst      (rst),
        .rxd      (uart_rx),
        .rx_valid (rx_valid),
        .rx_data  (rx_data)
    );

    // Bytes arriving while full are lost, RTS keeps the host off
    byte_fifo #(.DEPTH(RX_FIFO_DEPTH)) u_rx_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (rx_valid),
        .wr_ready (),
        .wr_data  (rx_data),
        .rd_valid (in_valid),
        .rd_ready (in_ready),
        .rd_data  (in_data),
        .level    (rx_level)
    );

    frame_engine u_engine (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_data     (in_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .bus_valid   (bus_valid),
        .bus_write   (bus_write),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .bus_ready   (bus_ready),
        .bus_rdata   (bus_rdata),
        .bus_status  (bus_status),
        .clear_stats (clear_stats),
        .frame_count (frame_count),
        .error_count (error_count)
    );

    reg_block u_regs (
        .clk         (clk),
        .rst         (rst),
        .bus_valid   (bus_valid),
        .bus_write   (bus_write),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .bus_ready   (bus_ready),
        .bus_rdata   (bus_rdata),
        .bus_status  (bus_status),
        .clear_stats (clear_stats),
        .frame_count (frame_count),
        .error_count (error_count)
    );

    byte_fifo #(.DEPTH(TX_FIFO_DEPTH)) u_tx_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (out_valid),
        .wr_ready (out_ready),
        .wr_data  (out_data),
        .rd_valid (tx_valid),
        .rd_ready (tx_ready),
        .rd_data  (tx_data),
        .level    ()
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_valid (tx_valid),
        .tx_data  (tx_data),
        .tx_ready (tx_ready),
        .cts_n    (uart_cts_n),
        .txd      (uart_tx)
    );

    // RTS released near full, heartbeat free running
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            uart_rts_n <= 1'b1;     // Not ready during reset
            hb_cnt     <= '0;
        end else begin
            uart_rts_n <= (rx_level >= RX_HIGH_MARK);
            hb_cnt     <= hb_cnt + 1'b1;
        end
    end

    assign led = hb_cnt[HEARTBEAT_BIT];

endmodule

`default_nettype wire

/* uart_rx.sv */
`default_nettype none

module uart_rx import uart_bridge_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       rxd,
    output logic       rx_valid,
    output logic [7:0] rx_data
);

    localparam int CW = $clog2(CLKS_PER_BIT);

    // State encoding
    localparam logic [1:0] RX_IDLE  = 2'd0;
    localparam logic [1:0] RX_START = 2'd1;
    localparam logic [1:0] RX_DATA  = 2'd2;
    localparam logic [1:0] RX_STOP  = 2'd3;

    logic          rxd_m;       // First sync stage
    logic          rxd_s;       // Synchronized line
    logic          rxd_d;       // Previous synchronized value
    logic [1:0]    state;
    logic [CW-1:0] clk_cnt;     // Cycles within current bit
    logic [2:0]    bit_cnt;     // Data bit index

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rxd_m    <= 1'b1;
            rxd_s    <= 1'b1;
            rxd_d    <= 1'b1;
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
            rx_data  <= '0;
        end else begin
            rxd_m    <= rxd;
            rxd_s    <= rxd_m;
            rxd_d    <= rxd_s;
            rx_valid <= 1'b0;   // Single cycle pulse
            case (state)
                RX_IDLE: begin
                    if (rxd_d && !rxd_s) begin   // Falling edge of start bit
                        state   <= RX_START;
                        clk_cnt <= '0;
                    end
                end
                RX_START: begin
                    if (clk_cnt == CW'(CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        // Glitch if the line went back high
                        state   <= rxd_s ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == CW'(CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        rx_data <= {rxd_s, rx_data[7:1]};   // LSB first
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= RX_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    if (clk_cnt == CW'(CLKS_PER_BIT - 1)) begin
                        clk_cnt  <= '0;
                        rx_valid <= rxd_s;   // Framing error drops the byte
                        state    <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* uart_tx.sv */
`default_nettype none

module uart_tx import uart_bridge_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_valid,
    input  logic [7:0] tx_data,
    output logic       tx_ready,
    input  logic       cts_n,
    output logic       txd
);

    localparam int CW = $clog2(CLKS_PER_BIT);

    logic          cts_m;
    logic          cts_s;       // Synchronized CTS
    logic          busy;
    logic [9:0]    shreg;       // Stop, data, start
    logic [3:0]    bit_cnt;
    logic [CW-1:0] clk_cnt;

    assign tx_ready = !busy && !cts_s;  // New byte only when peer is ready
    assign txd      = shreg[0];         // Idle shreg is all ones

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cts_m   <= 1'b1;
            cts_s   <= 1'b1;
            busy    <= 1'b0;
            shreg   <= '1;
            bit_cnt <= '0;
            clk_cnt <= '0;
        end else begin
            cts_m <= cts_n;
            cts_s <= cts_m;
            if (!busy) begin
                if (tx_valid && tx_ready) begin
                    shreg   <= {1'b1, tx_data, 1'b0};
                    busy    <= 1'b1;
                    bit_cnt <= '0;
                    clk_cnt <= '0;
                end
            end else if (clk_cnt == CW'(CLKS_PER_BIT - 1)) begin
                clk_cnt <= '0;
                shreg   <= {1'b1, shreg[9:1]};   // Refill with idle level
                if (bit_cnt == 4'd9)
                    busy <= 1'b0;                // Stop bit done
                else
                    bit_cnt <= bit_cnt + 1'b1;
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
